/* cpu_config.svh */
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Datapath widths
`define CPU_XLEN      32
`define CPU_PC_W      19
`define CPU_INSTR_W   16
`define CPU_REG_AW    4

// r15 doubles as the program counter
`define CPU_PC_REG    15

`define CPU_MEM_AW    18  // Word address, PC bits 18:1

// Debug port
`define CPU_DBG_W     64
`define CPU_DBG_CMD_W 8

`endif

/* cpu_pkg.sv */
`include "cpu_config.svh"

package cpu_pkg;

  // Instruction bits 15:12
  typedef enum logic [3:0] {
    OP_ADD   = 4'h0,
    OP_SUB   = 4'h1,
    OP_XOR   = 4'h2,
    OP_AND   = 4'h3,
    OP_ORR   = 4'h4,
    OP_CONST = 4'hA,
    OP_BEQ   = 4'hB,
    OP_BLT   = 4'hC,
    OP_BLE   = 4'hD,
    OP_BLTS  = 4'hE
  } opcode_e;

  typedef enum logic [`CPU_DBG_CMD_W-1:0] {
    DBG_STATUS = 8'd0,
    DBG_HALT   = 8'd1,
    DBG_RESUME = 8'd2
  } dbg_cmd_e;

  // One stage's use of the register port this cycle
  typedef struct packed {
    logic                   en;
    logic                   write;
    logic [`CPU_REG_AW-1:0] addr;
    logic [`CPU_XLEN-1:0]   wdata;
  } reg_req_t;

  typedef struct packed {
    logic [`CPU_INSTR_W-1:0] instr;
    logic [`CPU_PC_W-1:0]    next_pc;
  } fetch_pkt_t;

  typedef struct packed {
    logic [`CPU_INSTR_W-1:0] instr;
    logic [`CPU_XLEN-1:0]    a;      // Operand A as read by decode
  } op_pkt_t;

endpackage

/* debug_ctrl.sv */
`timescale 1ns/1ps
`include "cpu_config.svh"

module debug_ctrl (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   dbg_start,
  input  cpu_pkg::dbg_cmd_e      dbg_cmd,
  input  logic                   halted,
  output logic                   dbg_accepted,
  output logic                   dbg_available,
  output logic [`CPU_DBG_W-1:0]  dbg_value,
  output logic                   hlt_req
);
  import cpu_pkg::*;

  typedef enum logic [1:0] {D_IDLE, D_WAIT, D_REPLY} state_t;

  localparam logic [`CPU_DBG_W-1:0] DBG_ONE = 1;

  state_t                state;
  dbg_cmd_e              cmd_q;
  logic                  reply_now;
  logic [`CPU_DBG_W-1:0] reply_val;

  // Reply condition for the latched command
  always_comb begin
    reply_now = 1'b1;
    reply_val = '0;
    case (cmd_q)
      DBG_STATUS: reply_val = {{(`CPU_DBG_W-1){1'b0}}, halted};
      DBG_HALT: begin
        reply_now = halted;
        reply_val = DBG_ONE;
      end
      DBG_RESUME: begin
        reply_now = !halted;
        reply_val = DBG_ONE;
      end
      default: reply_val = '0;  // Unknown command answers 0
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state         <= D_IDLE;
      dbg_accepted  <= 1'b0;
      dbg_available <= 1'b0;
      hlt_req       <= 1'b1;  // Come out of reset halted
    end else begin
      dbg_accepted  <= 1'b0;
      dbg_available <= 1'b0;
      case (state)
        D_IDLE: begin
          if (dbg_start) begin
            dbg_accepted <= 1'b1;
            state        <= D_WAIT;
            if (dbg_cmd == DBG_HALT) hlt_req <= 1'b1;
            else if (dbg_cmd == DBG_RESUME) hlt_req <= 1'b0;
          end
        end
        D_WAIT: begin
          if (reply_now) begin
            dbg_available <= 1'b1;
            state         <= D_REPLY;
          end
        end
        default: state <= D_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == D_IDLE && dbg_start) cmd_q <= dbg_cmd;
    if (state == D_WAIT && reply_now) dbg_value <= reply_val;
  end

  a_acc_avail_excl: assert property (@(posedge clk) disable iff (rst)
    !(dbg_accepted && dbg_available));

endmodule

/* fetch_stage.sv */
`timescale 1ns/1ps
`include "cpu_config.svh"

module fetch_stage (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    hlt_req,
  input  logic                    retire,
  input  logic                    mem_ack,
  input  logic [`CPU_INSTR_W-1:0] mem_rdata,
  input  logic [`CPU_XLEN-1:0]    reg_rdata,
  output logic                    halted,
  output logic [`CPU_MEM_AW-1:0]  mem_adr,
  output logic                    mem_req,
  output cpu_pkg::reg_req_t       reg_req,
  output cpu_pkg::fetch_pkt_t     fpkt,
  output logic                    fpkt_valid
);
  import cpu_pkg::*;

  typedef enum logic [1:0] {F_CHECK, F_PC, F_WAIT, F_IDLE} state_t;

  localparam logic [`CPU_REG_AW-1:0] PC_REG  = `CPU_PC_REG;
  localparam logic [`CPU_PC_W-1:0]   PC_STEP = 2;

  state_t               state;
  logic [`CPU_PC_W-1:0] pc_next;
  logic [`CPU_PC_W-1:0] next_pc_q;

  assign pc_next = reg_rdata[`CPU_PC_W-1:0] + PC_STEP;  // r15 is on the port in F_PC

  always_comb begin
    reg_req = '0;
    case (state)
      F_CHECK: begin
        reg_req.en   = 1'b1;
        reg_req.addr = PC_REG;
      end
      F_PC: begin
        reg_req.en    = 1'b1;
        reg_req.write = 1'b1;
        reg_req.addr  = PC_REG;
        reg_req.wdata = {{(`CPU_XLEN-`CPU_PC_W){1'b0}}, pc_next};
      end
      default: reg_req = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= F_CHECK;
      halted  <= 1'b0;
      mem_req <= 1'b0;
    end else begin
      case (state)
        F_CHECK: begin
          halted <= hlt_req;  // Halt only taken between instructions
          if (!hlt_req) state <= F_PC;
        end
        F_PC: begin
          mem_req <= 1'b1;
          state   <= F_WAIT;
        end
        F_WAIT: begin
          if (mem_ack) begin
            mem_req <= 1'b0;
            state   <= retire ? F_CHECK : F_IDLE;  // CONST and no-ops retire at ack
          end
        end
        default: if (retire) state <= F_CHECK;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == F_PC) begin
      mem_adr   <= reg_rdata[`CPU_PC_W-1:1];
      next_pc_q <= pc_next;
    end
  end

  assign fpkt_valid = (state == F_WAIT) && mem_ack;
  assign fpkt       = '{instr: mem_rdata, next_pc: next_pc_q};

  a_req_until_ack: assert property (@(posedge clk) disable iff (rst)
    mem_req && !mem_ack |=> mem_req);

endmodule

/* decode_stage.sv */
`timescale 1ns/1ps
`include "cpu_config.svh"

module decode_stage (
  input  logic                 clk,
  input  logic                 rst,
  input  cpu_pkg::fetch_pkt_t  fpkt,
  input  logic                 fpkt_valid,
  input  logic [`CPU_XLEN-1:0] reg_rdata,
  output cpu_pkg::reg_req_t    reg_req,
  output cpu_pkg::op_pkt_t     opkt,
  output logic                 opkt_valid,
  output logic                 retire
);
  import cpu_pkg::*;

  opcode_e                 op;
  logic                    is_const;
  logic                    needs_a;
  logic                    wait_a;   // Operand A read in flight
  logic [`CPU_INSTR_W-1:0] instr_q;

  assign op = opcode_e'(fpkt.instr[15:12]);

  always_comb begin
    is_const = 1'b0;
    needs_a  = 1'b0;
    case (op)
      OP_CONST: is_const = 1'b1;
      OP_ADD, OP_SUB, OP_XOR, OP_AND, OP_ORR,
      OP_BEQ, OP_BLT, OP_BLE, OP_BLTS: needs_a = 1'b1;
      default: needs_a = 1'b0;  // Retires as a no-op
    endcase
  end

  always_comb begin
    reg_req = '0;
    if (fpkt_valid && is_const) begin
      reg_req.en    = 1'b1;
      reg_req.write = 1'b1;
      reg_req.addr  = fpkt.instr[3:0];
      reg_req.wdata = {{(`CPU_XLEN-8){1'b0}}, fpkt.instr[11:4]};
    end else if (fpkt_valid && needs_a) begin
      reg_req.en   = 1'b1;
      reg_req.addr = fpkt.instr[11:8];
    end
  end

  assign retire = fpkt_valid && !needs_a;

  always_ff @(posedge clk) begin
    if (rst) begin
      wait_a <= 1'b0;
    end else begin
      wait_a <= fpkt_valid && needs_a;
    end
  end

  always_ff @(posedge clk) begin
    if (fpkt_valid) instr_q <= fpkt.instr;
  end

  // A is on the port the cycle after its address
  assign opkt_valid = wait_a;
  assign opkt       = '{instr: instr_q, a: reg_rdata};

endmodule

/* execute_stage.sv */
`timescale 1ns/1ps
`include "cpu_config.svh"

module execute_stage (
  input  logic                 clk,
  input  logic                 rst,
  input  cpu_pkg::op_pkt_t     opkt,
  input  logic                 opkt_valid,
  input  logic [`CPU_XLEN-1:0] reg_rdata,
  output cpu_pkg::reg_req_t    reg_req,
  output logic                 retire
);
  import cpu_pkg::*;

  typedef enum logic [1:0] {X_IDLE, X_OPB, X_JUMP} state_t;

  localparam logic [`CPU_REG_AW-1:0] PC_REG = `CPU_PC_REG;

  state_t                  state;
  logic [`CPU_INSTR_W-1:0] instr_q;
  logic [`CPU_XLEN-1:0]    a_q;
  opcode_e                 op;
  logic [`CPU_XLEN-1:0]    alu_res;
  logic                    is_alu;
  logic                    taken;

  assign op = opcode_e'(instr_q[15:12]);

  // B arrives on reg_rdata in X_OPB
  always_comb begin
    alu_res = '0;
    is_alu  = 1'b1;
    taken   = 1'b0;
    case (op)
      OP_ADD: alu_res = a_q + reg_rdata;
      OP_SUB: alu_res = a_q - reg_rdata;
      OP_XOR: alu_res = a_q ^ reg_rdata;
      OP_AND: alu_res = a_q & reg_rdata;
      OP_ORR: alu_res = a_q | reg_rdata;
      OP_BEQ: begin
        is_alu = 1'b0;
        taken  = (a_q == reg_rdata);
      end
      OP_BLT: begin
        is_alu = 1'b0;
        taken  = (a_q < reg_rdata);
      end
      OP_BLE: begin
        is_alu = 1'b0;
        taken  = (a_q <= reg_rdata);
      end
      OP_BLTS: begin
        is_alu = 1'b0;
        taken  = ($signed(a_q) < $signed(reg_rdata));
      end
      default: is_alu = 1'b0;
    endcase
  end

  always_comb begin
    reg_req = '0;
    retire  = 1'b0;
    case (state)
      X_IDLE: begin
        if (opkt_valid) begin
          reg_req.en   = 1'b1;
          reg_req.addr = opkt.instr[7:4];  // Operand B
        end
      end
      X_OPB: begin
        if (is_alu) begin
          reg_req.en    = 1'b1;
          reg_req.write = 1'b1;
          reg_req.addr  = instr_q[3:0];
          reg_req.wdata = alu_res;
          retire        = 1'b1;
        end else if (taken) begin
          reg_req.en   = 1'b1;
          reg_req.addr = instr_q[3:0];  // Branch target
        end else begin
          retire = 1'b1;
        end
      end
      default: begin
        reg_req.en    = 1'b1;
        reg_req.write = 1'b1;
        reg_req.addr  = PC_REG;
        reg_req.wdata = reg_rdata;
        retire        = 1'b1;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= X_IDLE;
    end else begin
      case (state)
        X_IDLE: if (opkt_valid) state <= X_OPB;
        X_OPB: state <= (!is_alu && taken) ? X_JUMP : X_IDLE;
        default: state <= X_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == X_IDLE && opkt_valid) begin
      instr_q <= opkt.instr;
      a_q     <= opkt.a;
    end
  end

endmodule

/* reg_port_drv.sv */
`timescale 1ns/1ps
`include "cpu_config.svh"

module reg_port_drv (
  input  logic                   clk,
  input  logic                   rst,
  input  cpu_pkg::reg_req_t      fetch_req,
  input  cpu_pkg::reg_req_t      decode_req,
  input  cpu_pkg::reg_req_t      exec_req,
  output logic [`CPU_REG_AW-1:0] reg_addr,
  output logic                   reg_write,
  output logic [`CPU_XLEN-1:0]   reg_wdata
);
  import cpu_pkg::*;

  reg_req_t sel;

  // Stages take turns, so at most one enable is set
  always_comb begin
    sel = '0;
    if (fetch_req.en) sel = fetch_req;
    else if (decode_req.en) sel = decode_req;
    else if (exec_req.en) sel = exec_req;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      reg_addr  <= '0;
      reg_write <= 1'b0;
    end else begin
      reg_write <= sel.en && sel.write;
      if (sel.en) reg_addr <= sel.addr;  // Address held when idle
    end
  end

  always_ff @(posedge clk) begin
    if (sel.en && sel.write) reg_wdata <= sel.wdata;
  end

  a_one_stage: assert property (@(posedge clk) disable iff (rst)
    $onehot0({fetch_req.en, decode_req.en, exec_req.en}));

endmodule

/* core_top.sv */
`timescale 1ns/1ps
`include "cpu_config.svh"

module core_top (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    dbg_start,
  input  cpu_pkg::dbg_cmd_e       dbg_cmd,
  output logic                    dbg_accepted,
  output logic                    dbg_available,
  output logic [`CPU_DBG_W-1:0]   dbg_value,
  output logic [`CPU_REG_AW-1:0]  reg_addr,
  output logic                    reg_write,
  output logic [`CPU_XLEN-1:0]    reg_wdata,
  input  logic [`CPU_XLEN-1:0]    reg_rdata,
  output logic [`CPU_MEM_AW-1:0]  mem_adr,
  output logic                    mem_req,
  input  logic                    mem_ack,
  input  logic [`CPU_INSTR_W-1:0] mem_rdata
);
  import cpu_pkg::*;

  logic       hlt_req;
  logic       halted;
  logic       dec_retire;
  logic       exe_retire;
  logic       fpkt_valid;
  logic       opkt_valid;
  fetch_pkt_t fpkt;
  op_pkt_t    opkt;
  reg_req_t   fetch_req;
  reg_req_t   decode_req;
  reg_req_t   exec_req;

  debug_ctrl i_debug (
    .clk, .rst, .dbg_start, .dbg_cmd, .halted,
    .dbg_accepted, .dbg_available, .dbg_value, .hlt_req
  );

  fetch_stage i_fetch (
    .clk, .rst, .hlt_req, .retire(dec_retire | exe_retire), .mem_ack, .mem_rdata,
    .reg_rdata, .halted, .mem_adr, .mem_req, .reg_req(fetch_req), .fpkt, .fpkt_valid
  );

  decode_stage i_decode (
    .clk, .rst, .fpkt, .fpkt_valid, .reg_rdata,
    .reg_req(decode_req), .opkt, .opkt_valid, .retire(dec_retire)
  );

  execute_stage i_execute (
    .clk, .rst, .opkt, .opkt_valid, .reg_rdata,
    .reg_req(exec_req), .retire(exe_retire)
  );

  reg_port_drv i_reg_port (
    .clk, .rst, .fetch_req, .decode_req, .exec_req,
    .reg_addr, .reg_write, .reg_wdata
  );

endmodule

/* tb_core.sv */
`timescale 1ns/1ps
`include "cpu_config.svh"

module tb_core;
  import cpu_pkg::*;

  localparam int NROWS = 21;
  localparam int LIMIT = NROWS * 40 + 200;
  localparam int STIM  = 1;  // Drive delay after the rising edge

  typedef struct packed {
    logic [15:0] instr;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] t;
    logic        rnd;      // Replace a and b with LCG values
    logic        halt;     // Issue HALT while this row runs
    logic        wr2;      // A second write follows the r15 update
    logic [3:0]  exp_reg;
    logic [31:0] exp_val;
  } row_t;

  logic                    clk;
  logic                    rst;
  logic                    dbg_start;
  dbg_cmd_e                dbg_cmd;
  logic                    dbg_accepted;
  logic                    dbg_available;
  logic [`CPU_DBG_W-1:0]   dbg_value;
  logic [`CPU_REG_AW-1:0]  reg_addr;
  logic                    reg_write;
  logic [`CPU_XLEN-1:0]    reg_wdata;
  logic [`CPU_XLEN-1:0]    reg_rdata;
  logic [`CPU_MEM_AW-1:0]  mem_adr;
  logic                    mem_req;
  logic                    mem_ack;
  logic [`CPU_INSTR_W-1:0] mem_rdata;

  logic [31:0] regs [16];
  logic [15:0] imem [0:262143];
  logic [3:0]  wr_addr_q [$];
  logic [31:0] wr_data_q [$];
  row_t        rows [NROWS];
  logic [31:0] seed = 32'h290b_f9cd;
  logic [18:0] pc;
  logic        mem_hold;
  int          wait_cnt;
  int          cycles;
  int          checks;
  int          errors;

  core_top i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Register file model with its write log
  assign reg_rdata = regs[reg_addr];
  always @(posedge clk) begin
    if (!rst && reg_write) begin
      regs[reg_addr] <= reg_wdata;
      wr_addr_q.push_back(reg_addr);
      wr_data_q.push_back(reg_wdata);
    end
  end

  always @(posedge clk) cycles <= cycles + 1;

  initial begin
    wait (cycles >= LIMIT);
    $display("Timeout after %0d cycles, the core stopped making progress", cycles);
    $display("CHECKS FAILED");
    $finish;
  end

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic logic [31:0] alu_expect(logic [3:0] op, logic [31:0] a, logic [31:0] b);
    case (op)
      4'h0: return a + b;
      4'h1: return a - b;
      4'h2: return a ^ b;
      4'h3: return a & b;
      default: return a | b;
    endcase
  endfunction

  task automatic check(string name, logic [31:0] exp, logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("Fail %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  // One cycle, memory model included; it acks only released requests
  task automatic tick();
    @(posedge clk);
    #STIM;
    mem_ack = 1'b0;
    if (mem_req && !mem_hold) begin
      if (wait_cnt < 0) wait_cnt = int'(lcg_next() % 32'd4);
      if (wait_cnt == 0) begin
        mem_ack   = 1'b1;
        mem_rdata = imem[mem_adr];
        mem_hold  = 1'b1;
        wait_cnt  = -1;
      end else begin
        wait_cnt--;
      end
    end
  endtask

  task automatic wait_fetch();
    while (!(mem_req && mem_hold && !mem_ack)) tick();
  endtask

  task automatic send_cmd(dbg_cmd_e cmd, output logic [63:0] val);
    logic acc_seen;
    tick();
    dbg_start = 1'b1;
    dbg_cmd   = cmd;
    tick();
    dbg_start = 1'b0;
    acc_seen  = dbg_accepted;
    while (!dbg_available) tick();
    check("dbg accepted before reply", 32'd1, {31'd0, acc_seen});
    val = dbg_value;
  endtask

  task automatic preload(logic [3:0] idx, logic [31:0] val);
    if (idx != 4'd15) regs[idx] <= val;  // r15 belongs to the core
  endtask

  task automatic check_log(string name, row_t r, logic [18:0] old_pc);
    check({name, " write count"}, r.wr2 ? 32'd2 : 32'd1, wr_addr_q.size());
    if (wr_addr_q.size() >= 1) begin
      check({name, " pc reg"}, 32'd15, {28'd0, wr_addr_q[0]});
      check({name, " pc value"}, {13'd0, old_pc + 19'd2}, wr_data_q[0]);
    end
    if (r.wr2 && wr_addr_q.size() >= 2) begin
      check({name, " dest reg"}, {28'd0, r.exp_reg}, {28'd0, wr_addr_q[1]});
      check({name, " dest value"}, r.exp_val, wr_data_q[1]);
    end
  endtask

  initial begin
    logic [63:0] val;
    row_t        r;
    string       name;
    rows[0]  = '{16'hA5A3, 32'h0, 32'h0, 32'h0, 1'b0, 1'b0, 1'b1, 4'd3, 32'h5A};
    rows[1]  = '{16'hAFF7, 32'h0, 32'h0, 32'h0, 1'b0, 1'b0, 1'b1, 4'd7, 32'hFF};
    rows[2]  = '{16'hA004, 32'h0, 32'h0, 32'h0, 1'b0, 1'b0, 1'b1, 4'd4, 32'h0};
    rows[3]  = '{16'h0123, 32'h0, 32'h0, 32'h0, 1'b1, 1'b0, 1'b1, 4'd3, 32'h0};
    rows[4]  = '{16'h1456, 32'h0, 32'h0, 32'h0, 1'b1, 1'b0, 1'b1, 4'd6, 32'h0};
    rows[5]  = '{16'h2789, 32'h0, 32'h0, 32'h0, 1'b1, 1'b0, 1'b1, 4'd9, 32'h0};
    rows[6]  = '{16'h3AB1, 32'h0, 32'h0, 32'h0, 1'b1, 1'b0, 1'b1, 4'd1, 32'h0};
    rows[7]  = '{16'h4CDE, 32'h0, 32'h0, 32'h0, 1'b1, 1'b0, 1'b1, 4'd14, 32'h0};
    rows[8]  = '{16'h0123, 32'hFFFFFFFF, 32'h2, 32'h0, 1'b0, 1'b0, 1'b1, 4'd3, 32'h1};
    rows[9]  = '{16'h1123, 32'h0, 32'h1, 32'h0, 1'b0, 1'b0, 1'b1, 4'd3, 32'hFFFFFFFF};
    rows[10] = '{16'hB123, 32'h5, 32'h5, 32'h200, 1'b0, 1'b0, 1'b1, 4'd15, 32'h200};
    rows[11] = '{16'hB123, 32'h5, 32'h6, 32'h480, 1'b0, 1'b0, 1'b0, 4'd0, 32'h0};
    rows[12] = '{16'hC123, 32'h3, 32'h80000000, 32'h10000, 1'b0, 1'b0, 1'b1, 4'd15, 32'h10000};
    rows[13] = '{16'hE123, 32'h3, 32'h80000000, 32'h600, 1'b0, 1'b0, 1'b0, 4'd0, 32'h0};
    rows[14] = '{16'hE123, 32'hFFFFFFFF, 32'h1, 32'h40000, 1'b0, 1'b0, 1'b1, 4'd15, 32'h40000};
    rows[15] = '{16'hC123, 32'hFFFFFFFF, 32'h1, 32'h700, 1'b0, 1'b0, 1'b0, 4'd0, 32'h0};
    rows[16] = '{16'hD123, 32'h7, 32'h7, 32'h300, 1'b0, 1'b0, 1'b1, 4'd15, 32'h300};
    rows[17] = '{16'hD123, 32'h7, 32'h6, 32'h800, 1'b0, 1'b0, 1'b0, 4'd0, 32'h0};
    rows[18] = '{16'h5123, 32'h0, 32'h0, 32'h0, 1'b0, 1'b0, 1'b0, 4'd0, 32'h0};
    rows[19] = '{16'h0123, 32'h0, 32'h0, 32'h0, 1'b1, 1'b1, 1'b1, 4'd3, 32'h0};
    rows[20] = '{16'hA126, 32'h0, 32'h0, 32'h0, 1'b0, 1'b0, 1'b1, 4'd6, 32'h12};
    for (int i = 0; i < 262144; i++) begin
      imem[i] = 16'h5000 | {4'h0, 12'(i >> 6) ^ 12'(i)};  // Stray fetches retire as no-ops
    end
    for (int i = 0; i < 16; i++) regs[i] <= 32'h0101_0101 * i;
    regs[15] <= 32'h100;
    pc        = 19'h100;
    rst       = 1'b1;
    dbg_start = 1'b0;
    dbg_cmd   = DBG_STATUS;
    mem_ack   = 1'b0;
    mem_rdata = '0;
    mem_hold  = 1'b1;
    wait_cnt  = -1;
    checks    = 0;
    errors    = 0;
    repeat (10) tick();
    rst = 1'b0;

    repeat (20) begin
      tick();
      check("no fetch while halted", 32'd0, {31'd0, mem_req});
    end
    send_cmd(DBG_STATUS, val);
    check("status after reset", 32'd1, val[31:0]);
    send_cmd(DBG_RESUME, val);

    wait_fetch();
    for (int i = 0; i < NROWS; i++) begin
      r    = rows[i];
      name = $sformatf("row %0d", i);
      check({name, " fetch address"}, {14'd0, pc[18:1]}, {14'd0, mem_adr});
      if (r.rnd) begin
        r.a       = lcg_next();
        r.b       = lcg_next();
        r.exp_val = alu_expect(r.instr[15:12], r.a, r.b);
      end
      wr_addr_q.delete();
      wr_data_q.delete();
      preload(r.instr[11:8], r.a);
      preload(r.instr[7:4], r.b);
      preload(r.instr[3:0], r.t);
      imem[mem_adr] = r.instr;
      mem_hold = 1'b0;
      if (r.halt) begin
        send_cmd(DBG_HALT, val);
        check({name, " write before halt"}, 32'd2, wr_addr_q.size());
        repeat (30) begin
          tick();
          check({name, " no fetch after halt"}, 32'd0, {31'd0, mem_req});
        end
        send_cmd(DBG_STATUS, val);
        check({name, " status halted"}, 32'd1, val[31:0]);
        send_cmd(DBG_RESUME, val);
      end
      wait_fetch();
      check_log(name, r, pc);
      if (r.wr2 && r.exp_reg == 4'd15) pc = r.exp_val[18:0];
      else pc = pc + 19'd2;
    end
    check("final fetch address", {14'd0, pc[18:1]}, {14'd0, mem_adr});

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

/* sim.f */
+incdir+.
cpu_pkg.sv
debug_ctrl.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
reg_port_drv.sv
core_top.sv
tb_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module tb_core -o tb_core_sim \
  && ./obj_dir/tb_core_sim | tee /dev/stderr | grep -q "ALL CHECKS PASSED" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
